/* fault_subsys.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/fault_pkg.sv
rtl/settle_timer.sv
rtl/fault_line_fsm.sv
rtl/error_status_reg.sv
rtl/fault_line_driver.sv
rtl/fault_subsys_top.sv
testbench/tb_fault_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fault_subsys testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

verilator --binary --timing --assert --top-module tb_fault_subsys -f fault_subsys.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_fault_subsys)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

echo "$sim_out" | grep -qxF ">>> PASS"
if [ $? -ne 0 ]; then
   exit 1
fi
exit 0

/* testbench/tb_fault_subsys.sv */
//##########################################################################
// Testbench for the fault reporting subsystem
// Clock, reset, bus and error stimulus, cycle reference model,
// immediate and concurrent assertions, error counts and final report
//##########################################################################

`timescale 1ns/1ps

`include "fault_subsys_defs.svh"

module tb_fault_subsys;

   // About 60 accesses of up to 30 cycles each, plus margin
   localparam int TIMEOUT_CYCLES = 2000;
   // Edges from entering settle to the check decision taking effect
   localparam int SETTLE_EDGES   = `SETTLE_CYCLES + 3;

   logic                   clk;
   logic                   reset;
   bus_pkg::bus_req_t      bus;
   fault_pkg::err_vec_t    err_events;
   bus_pkg::reg_data_t     rd_data;
   fault_pkg::fault_line_t nfault;

   // Reference model of flags and line
   fault_pkg::err_vec_t    m_flags;
   logic                   m_oe;
   logic                   m_level;
   logic                   m_oe_next;
   fault_pkg::err_vec_t    m_clr;
   // Line strobes expected on the coming edge
   logic                   exp_commit;
   logic                   exp_release;

   bus_pkg::reg_data_t     last_rd;   // rd_data seen in the last valid cycle
   int                     value_errs;
   int                     other_errs;
   int                     cycle_cnt;
   int unsigned            seed_ret;

   fault_subsys_top u_fault_subsys_top (
      .clk        (clk),
      .reset      (reset),
      .bus        (bus),
      .err_events (err_events),
      .rd_data    (rd_data),
      .nfault     (nfault)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   // Model update on each edge
   // Level follows the flags of the previous cycle
   always @(posedge clk or negedge reset) begin
      if (!reset) begin
         m_flags = '0;
         m_oe    = 1'b0;
         m_level = 1'b1;
      end else begin
         m_oe_next = exp_commit ? 1'b1 : (exp_release ? 1'b0 : m_oe);
         m_clr     = (exp_commit && bus.wr) ? fault_pkg::err_vec_t'(bus.wdata) : '0;
         m_level   = m_oe_next ? ~(|m_flags) : 1'b1;
         m_oe      = m_oe_next;
         // New strobes win over a clear
         m_flags   = (m_flags & ~m_clr) | err_events;
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Released line always sits high
   assert property (@(posedge clk) disable iff (!reset) !nfault.oe |-> nfault.level)
   else begin
      value_errs++;
      $display("FAILED nfault.level: got 0x%0h, expected 0x1 while oe is 0",
               $sampled(nfault.level));
   end

   // No read data outside an access
   assert property (@(posedge clk) disable iff (!reset) !bus.valid |-> rd_data == '0)
   else begin
      value_errs++;
      $display("FAILED rd_data: got 0x%0h, expected 0x0 while valid is low",
               $sampled(rd_data));
   end

   task automatic check_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      assert (got === exp)
      else begin
         value_errs++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // One cycle: compare at the falling edge, then drive the next inputs
   task automatic step(input logic valid, input logic commit, input logic rel,
                       input fault_pkg::err_vec_t ev);
      bus_pkg::reg_data_t exp_rd;
      exp_rd = '0;
      if (bus.valid && bus.addr == bus_pkg::reg_addr_t'(`UNIT_ADDR)) begin
         exp_rd = bus_pkg::reg_data_t'(m_flags);
      end
      check_eq("nfault.oe", 32'(nfault.oe), 32'(m_oe));
      check_eq("nfault.level", 32'(nfault.level), 32'(m_level));
      check_eq("rd_data", 32'(rd_data), 32'(exp_rd));
      if (bus.valid) begin
         last_rd = rd_data;
      end
      bus.valid   = valid;
      exp_commit  = commit;
      exp_release = rel;
      err_events  = ev;
      @(negedge clk);
   endtask

   // Random strobe on one source, pct percent of the time
   function automatic fault_pkg::err_vec_t rand_strobe(input int pct);
      fault_pkg::err_vec_t v;
      v = '0;
      if ($urandom_range(99) < pct) begin
         v = fault_pkg::err_vec_t'(1) << $urandom_range(`NUM_ERR_SRC - 1);
      end
      return v;
   endfunction

   function automatic bus_pkg::reg_addr_t foreign_addr();
      bus_pkg::reg_addr_t a;
      a = bus_pkg::reg_addr_t'($urandom);
      if (a == bus_pkg::reg_addr_t'(`UNIT_ADDR)) begin
         a = a ^ bus_pkg::reg_addr_t'(1);
      end
      return a;
   endfunction

   task automatic idle(input int n, input int pct);
      repeat (n) step(1'b0, 1'b0, 1'b0, rand_strobe(pct));
   endtask

   // One access with valid high for len edges
   // Matched: line taken one edge after the later of valid low and the check
   // Foreign: line released SETTLE_EDGES edges after the first valid edge
   task automatic run_access(input bus_pkg::reg_addr_t addr, input logic wr,
                             input bus_pkg::reg_data_t wdata, input int len,
                             input int pct, input fault_pkg::err_vec_t commit_ev);
      int                  i;
      int                  n_end;
      logic                match;
      fault_pkg::err_vec_t ev;
      match = (addr == bus_pkg::reg_addr_t'(`UNIT_ADDR));
      n_end = 1 + SETTLE_EDGES;
      if (match && len + 1 > SETTLE_EDGES) begin
         n_end = len + 2;
      end
      // Address, direction and data stay put until the next access
      bus.addr  = addr;
      bus.wr    = wr;
      bus.wdata = wdata;
      for (i = 1; i <= n_end; i++) begin
         ev = rand_strobe(pct);
         if (i == n_end) begin
            ev = ev | commit_ev;
         end
         step(i <= len, match && i == n_end, !match && i == n_end, ev);
      end
   endtask

   // Wait a bounded number of cycles for the line to reach a value
   task automatic wait_line(input logic oe, input logic level, input int limit,
                            input string what);
      int n;
      n = 0;
      while (!(nfault.oe === oe && nfault.level === level) && n < limit) begin
         step(1'b0, 1'b0, 1'b0, '0);
         n++;
      end
      assert (nfault.oe === oe && nfault.level === level)
      else begin
         other_errs++;
         $display("nFault line did not reach oe %0d and level %0d within %0d cycles after %s",
                  oe, level, limit, what);
      end
   endtask

   initial begin
      fault_pkg::err_vec_t old_flags;
      fault_pkg::err_vec_t cev;
      bus_pkg::reg_data_t  wdata;
      bus_pkg::reg_addr_t  addr;
      int                  k;
      int                  len;

      seed_ret    = $urandom(32'h2746_0040);
      clk         = 1'b0;
      reset       = 1'b0;
      bus         = '0;
      err_events  = '0;
      exp_commit  = 1'b0;
      exp_release = 1'b0;
      last_rd     = '0;
      value_errs  = 0;
      other_errs  = 0;
      cycle_cnt   = 0;

      repeat (5) @(negedge clk);
      reset = 1'b1;

      // Quiet line after reset
      idle(4, 0);
      wait_line(1'b0, 1'b1, 0, "reset");

      // Latched errors read back, line pulled low after the access
      for (k = 0; k < 4; k++) begin
         step(1'b0, 1'b0, 1'b0, rand_strobe(100));
         run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b0, '0, $urandom_range(10, 15), 0, '0);
         wait_line(1'b1, 1'b0, 2, "a matched read");
         idle(2, 0);
      end

      // Write-one-to-clear, with a strobe in the commit cycle on a cleared bit
      for (k = 0; k < 4; k++) begin
         step(1'b0, 1'b0, 1'b0, fault_pkg::err_vec_t'($urandom));
         old_flags = m_flags;
         wdata     = bus_pkg::reg_data_t'($urandom);
         cev       = fault_pkg::err_vec_t'(wdata & (~wdata + 1'b1));
         run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b1, wdata,
                    $urandom_range(3, 12), 0, cev);
         run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b0, '0, 9, 0, '0);
         check_eq("rd_data", 32'(last_rd),
                  32'((old_flags & ~fault_pkg::err_vec_t'(wdata)) | cev));
      end
      run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b1, 8'hFF, 10, 0, '0);
      wait_line(1'b1, 1'b1, 2, "clearing every flag");

      // Foreign address hands the line back and leaves the flags alone
      // Foreign writes carry all ones so a wrong clear would show
      for (k = 0; k < 3; k++) begin
         step(1'b0, 1'b0, 1'b0, rand_strobe(100));
         old_flags = m_flags;
         run_access(foreign_addr(), 1'(k), 8'hFF, $urandom_range(1, 8), 0, '0);
         wait_line(1'b0, 1'b1, 0, "a foreign access");
         run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b0, '0, 9, 0, '0);
         check_eq("rd_data", 32'(last_rd), 32'(old_flags));
      end

      // Live level while driving, single sources then several at once
      run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b1, 8'hFF, 2, 0, '0);
      for (k = 0; k < 4; k++) begin
         if (k < 3) begin
            step(1'b0, 1'b0, 1'b0, rand_strobe(100));
         end else begin
            step(1'b0, 1'b0, 1'b0, fault_pkg::err_vec_t'($urandom) | 8'h81);
         end
         wait_line(1'b1, 1'b0, 2, "an error strobe");
         run_access(bus_pkg::reg_addr_t'(`UNIT_ADDR), 1'b1, 8'hFF, 2, 0, '0);
         wait_line(1'b1, 1'b1, 2, "clearing every flag");
      end

      // Random back-to-back traffic, short accesses included
      for (k = 0; k < 30; k++) begin
         if ($urandom_range(2) == 0) begin
            addr = foreign_addr();
            len  = $urandom_range(1, 8);
         end else begin
            addr = bus_pkg::reg_addr_t'(`UNIT_ADDR);
            len  = $urandom_range(1, 20);
         end
         run_access(addr, 1'($urandom_range(1)), bus_pkg::reg_data_t'($urandom), len, 10, '0);
         if (addr == bus_pkg::reg_addr_t'(`UNIT_ADDR)) begin
            check_eq("nfault.oe", 32'(nfault.oe), 32'(1));
         end
         idle($urandom_range(1, 4), 10);
      end
      idle(3, 0);

      $display("Run finished after %0d cycles: %0d value errors, %0d other errors",
               cycle_cnt, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* rtl/fault_subsys_top.sv */
//##########################################################################
// Fault reporting subsystem top level
// Settle timer, nFault FSM, error status register and line driver
//##########################################################################

`timescale 1ns/1ps

module fault_subsys_top (
   input  logic                   clk,
   input  logic                   reset,
   input  bus_pkg::bus_req_t      bus,
   input  fault_pkg::err_vec_t    err_events,
   output bus_pkg::reg_data_t     rd_data,
   output fault_pkg::fault_line_t nfault
);

   // FSM and timer handshake
   logic timer_start;
   logic timer_done;

   // Line control strobes from the FSM
   logic set_release;
   logic set_commit;

   // Status to FSM and driver
   logic addr_match;
   logic err_pending;

   settle_timer u_settle_timer (
      .clk   (clk),
      .reset (reset),
      .start (timer_start),
      .done  (timer_done)
   );

   fault_line_fsm u_fault_line_fsm (
      .clk         (clk),
      .reset       (reset),
      .bus_valid   (bus.valid),
      .addr_match  (addr_match),
      .timer_done  (timer_done),
      .timer_start (timer_start),
      .set_release (set_release),
      .set_commit  (set_commit)
   );

   error_status_reg u_error_status_reg (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .err_events  (err_events),
      .set_commit  (set_commit),
      .addr_match  (addr_match),
      .rd_data     (rd_data),
      .err_pending (err_pending)
   );

   fault_line_driver u_fault_line_driver (
      .clk         (clk),
      .reset       (reset),
      .set_release (set_release),
      .set_commit  (set_commit),
      .err_pending (err_pending),
      .nfault      (nfault)
   );

endmodule

/* rtl/fault_line_driver.sv */
//##########################################################################
// nFault line driver
// Output enable set by commit and cleared by release,
// registered line level from the pending error summary
//##########################################################################

`timescale 1ns/1ps

module fault_line_driver (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   set_release,
   input  logic                   set_commit,
   input  logic                   err_pending,
   output fault_pkg::fault_line_t nfault
);

   logic oe_q;
   logic level_q;
   // Enable value for the next cycle
   logic oe_next;

   // Commit takes the line, release hands it back
   always_comb begin
      oe_next = oe_q;
      if (set_commit) begin
         oe_next = 1'b1;
      end else if (set_release) begin
         oe_next = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         oe_q    <= 1'b0;
         level_q <= 1'b1;
      end else begin
         oe_q    <= oe_next;
         // Active low fault, idle high when not driving
         level_q <= oe_next ? ~err_pending : 1'b1;
      end
   end

   assign nfault.oe    = oe_q;
   assign nfault.level = level_q;

endmodule

/* rtl/error_status_reg.sv */
//##########################################################################
// Error status register
// Sticky error flags with write-one-to-clear, unit address decode,
// read data mux and the pending summary for the fault line
//##########################################################################

`timescale 1ns/1ps

`include "fault_subsys_defs.svh"

module error_status_reg (
   input  logic                 clk,
   input  logic                 reset,
   input  bus_pkg::bus_req_t    bus,
   input  fault_pkg::err_vec_t  err_events,
   input  logic                 set_commit,
   output logic                 addr_match,
   output bus_pkg::reg_data_t   rd_data,
   output logic                 err_pending
);

   // Sticky flags, one per source
   fault_pkg::err_vec_t flags;
   // Bits to clear this cycle
   fault_pkg::err_vec_t clr_mask;

   // Only this block compares the bus address
   assign addr_match = (bus.addr == bus_pkg::reg_addr_t'(`UNIT_ADDR));

   // Clear applies when a matched write access commits
   // The host keeps wr and wdata stable until then
   always_comb begin
      clr_mask = '0;
      if (set_commit && bus.wr) begin
         clr_mask = fault_pkg::err_vec_t'(bus.wdata);
      end
   end

   // New events take priority over a clear of the same bit
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         flags <= '0;
      end else begin
         flags <= (flags & ~clr_mask) | err_events;
      end
   end

   // Read data only while this unit is addressed
   always_comb begin
      if (addr_match && bus.valid) begin
         rd_data = bus_pkg::reg_data_t'(flags);
      end else begin
         rd_data = '0;
      end
   end

   // Any flag set
   assign err_pending = |flags;

endmodule

/* rtl/fault_line_fsm.sv */
//##########################################################################
// nFault control FSM
// Three-section Moore machine sequencing settle, check, release or commit
//##########################################################################

`timescale 1ns/1ps

module fault_line_fsm (
   input  logic clk,
   input  logic reset,
   input  logic bus_valid,
   input  logic addr_match,
   input  logic timer_done,
   output logic timer_start,
   output logic set_release,
   output logic set_commit
);

   fault_pkg::fault_state_t state;
   fault_pkg::fault_state_t next_state;

   // High in the first cycle of FS_SETTLE only
   logic settle_entry;

   // State register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state        <= fault_pkg::FS_IDLE;
         settle_entry <= 1'b0;
      end else begin
         state        <= next_state;
         // Marks the IDLE to SETTLE transition
         settle_entry <= (state == fault_pkg::FS_IDLE) && bus_valid;
      end
   end

   // Next state logic
   always_comb begin
      next_state = state;
      case (state)
         fault_pkg::FS_IDLE: begin
            if (bus_valid) begin
               next_state = fault_pkg::FS_SETTLE;
            end
         end
         fault_pkg::FS_SETTLE: begin
            // Address lines may still be moving until the timer ends
            if (timer_done) begin
               next_state = fault_pkg::FS_CHECK;
            end
         end
         fault_pkg::FS_CHECK: begin
            if (!addr_match) begin
               next_state = fault_pkg::FS_RELEASE;
            end else if (bus_valid) begin
               next_state = fault_pkg::FS_WAIT_END;
            end else begin
               // Short access, already over
               next_state = fault_pkg::FS_COMMIT;
            end
         end
         fault_pkg::FS_RELEASE: begin
            next_state = fault_pkg::FS_IDLE;
         end
         fault_pkg::FS_WAIT_END: begin
            if (!bus_valid) begin
               next_state = fault_pkg::FS_COMMIT;
            end
         end
         fault_pkg::FS_COMMIT: begin
            next_state = fault_pkg::FS_IDLE;
         end
         default: begin
            next_state = fault_pkg::FS_IDLE;
         end
      endcase
   end

   // Moore outputs
   assign timer_start = settle_entry;
   assign set_release = (state == fault_pkg::FS_RELEASE);
   assign set_commit  = (state == fault_pkg::FS_COMMIT);

endmodule

/* rtl/settle_timer.sv */
//##########################################################################
// Bus settle timer
// Down counter loaded on start, single-cycle done after SETTLE_CYCLES
//##########################################################################

`timescale 1ns/1ps

`include "fault_subsys_defs.svh"

module settle_timer (
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic done
);

   // Cycles left in the current count
   logic [`SETTLE_CNT_WIDTH-1:0] cnt;
   // Count in progress
   logic                         busy;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         cnt  <= '0;
         busy <= 1'b0;
      end else if (start) begin
         // Start always reloads, also in the middle of a count
         cnt  <= `SETTLE_CNT_WIDTH'(`SETTLE_CYCLES);
         busy <= 1'b1;
      end else if (busy) begin
         cnt <= cnt - 1'b1;
         // Count reaches zero on this edge
         if (cnt == `SETTLE_CNT_WIDTH'(1)) begin
            busy <= 1'b0;
         end
      end
   end

   // Last cycle of the count
   // SETTLE_CYCLES cycles after the start cycle
   // A restart in the same cycle suppresses it
   assign done = busy && (cnt == `SETTLE_CNT_WIDTH'(1)) && !start;

endmodule

/* rtl/fault_pkg.sv */
//##########################################################################
// Types for the fault reporting side
// Error flag vector, nFault line pair and the fault line FSM states
//##########################################################################

`include "fault_subsys_defs.svh"

package fault_pkg;

   // One bit per error source
   typedef logic [`NUM_ERR_SRC-1:0] err_vec_t;

   // Open-drain nFault leaves the block as enable and level
   typedef struct packed {
      logic oe;       // 1 while this unit drives the line
      logic level;    // Driven level, low means a fault is pending
   } fault_line_t;

   // Fault line FSM states
   typedef enum logic [2:0] {
      FS_IDLE,        // Wait for address valid
      FS_SETTLE,      // Wait for the settle timer
      FS_CHECK,       // Look at the address match
      FS_RELEASE,     // Another unit is addressed
      FS_WAIT_END,    // Wait for address valid to fall
      FS_COMMIT       // Access over, take the line
   } fault_state_t;

endpackage

/* rtl/bus_pkg.sv */
//##########################################################################
// Types for the host register bus
// Address and data words, and one host access as a packed struct
//##########################################################################

`include "fault_subsys_defs.svh"

package bus_pkg;

   // Register address as seen on the bus
   typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;

   // One data word, read or write
   typedef logic [`DATA_WIDTH-1:0] reg_data_t;

   // One host access
   // valid is a level held for the whole access
   typedef struct packed {
      logic      valid;
      logic      wr;      // 1 for write, 0 for read
      reg_addr_t addr;
      reg_data_t wdata;
   } bus_req_t;

endpackage

/* rtl/fault_subsys_defs.svh */
//##########################################################################
// Build constants for the fault-reporting block
// Unit bus address, bus widths, error source count and settle delay
//##########################################################################

`ifndef FAULT_SUBSYS_DEFS_SVH
`define FAULT_SUBSYS_DEFS_SVH

// Address this unit answers to on the shared register bus
`define UNIT_ADDR        8'h2C

// Host register bus widths
`define ADDR_WIDTH       8
`define DATA_WIDTH       8

// One sticky flag per error source, read back as a single data word
`define NUM_ERR_SRC      8

// Clock cycles to wait after address valid before the match is trusted
`define SETTLE_CYCLES    5
`define SETTLE_CNT_WIDTH 3

`endif
